// File: source/sd_data_pkg.sv
package sd_data_pkg;

// ==========================================================================
// widths and sizes
// ==========================================================================
localparam int blk_cnt_w   = 4;
localparam int tmo_w       = 16;
localparam int byte_w      = 8;
localparam int block_bytes = 4;
localparam int fifo_depth  = 16;
localparam int fifo_lvl_w  = 5;
localparam int fifo_ptr_w  = 4;
localparam int bit_cnt_w   = 3;
localparam int byte_cnt_w  = 2;

// ==========================================================================
// data control FSM, one-hot
// ==========================================================================
localparam logic [5:0] st_reset           = 6'b000001;
localparam logic [5:0] st_idle            = 6'b000010;
localparam logic [5:0] st_setting_outputs = 6'b000100;
localparam logic [5:0] st_check_fifo      = 6'b001000;
localparam logic [5:0] st_transmit        = 6'b010000;
localparam logic [5:0] st_ack             = 6'b100000;

// data line phy states.
localparam logic [2:0] ph_idle    = 3'd0;
localparam logic [2:0] ph_wr_data = 3'd1;
localparam logic [2:0] ph_wr_end  = 3'd2;
localparam logic [2:0] ph_wr_stop = 3'd3;
localparam logic [2:0] ph_rd_wait = 3'd4;
localparam logic [2:0] ph_rd_data = 3'd5;
localparam logic [2:0] ph_rd_end  = 3'd6;
localparam logic [2:0] ph_done    = 3'd7;

endpackage

// File: source/sd_dat_ctrl_if.sv
`timescale 1ns/100ps

interface sd_dat_ctrl_if
    import sd_data_pkg::*;
();

    logic                 strobe;
    logic                 ack_out;
    logic [blk_cnt_w-1:0] blocks;
    logic [tmo_w-1:0]     timeout_value;
    logic                 timeout_enable;
    logic                 write_read;     // 1 = write to card.
    logic                 multiple;
    logic                 idle;

    logic                 serial_ready;
    logic                 complete;
    logic                 timeout;
    logic                 ack_in;

    modport ctrl (
        output strobe, ack_out, blocks, timeout_value, timeout_enable,
        output write_read, multiple, idle,
        input  serial_ready, complete, timeout, ack_in
    );

    modport phy (
        input  strobe, ack_out, blocks, timeout_value, timeout_enable,
        input  write_read, multiple, idle,
        output serial_ready, complete, timeout, ack_in
    );

endinterface

// File: source/sd_fifo_if.sv
`timescale 1ns/100ps

interface sd_fifo_if
    import sd_data_pkg::*;
();

    logic              pop;
    logic              push;
    logic [byte_w-1:0] wdata;
    logic [byte_w-1:0] rdata;   // show-ahead head of the fifo.
    logic              empty;
    logic              full;

    modport phy (
        output pop, push, wdata,
        input  rdata, empty, full
    );

    modport fifo (
        input  pop, push, wdata,
        output rdata, empty, full
    );

endinterface

// File: source/sd_timeout_timer.sv
`timescale 1ns/100ps

module sd_timeout_timer
    import sd_data_pkg::*;
(
    input  logic             CLK,
    input  logic             RESET_L,
    input  logic             load,
    input  logic             run,
    input  logic             enable,
    input  logic [tmo_w-1:0] value,
    output logic             expired
);

logic [tmo_w-1:0] count;
logic             armed;

// stays expired until the next load.
assign expired = armed && (count == '0);

always_ff @(posedge CLK)
begin
    if (!RESET_L)
    begin
        count <= '0;
        armed <= 1'b0;
    end
    else if (load)
    begin
        count <= value;
        armed <= enable;
    end
    else if (run && enable && (count != '0))
    begin
        count <= count - 1'b1;
    end
end

endmodule

// File: source/sd_data_ctrl.sv
`timescale 1ns/100ps

module sd_data_ctrl
    import sd_data_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET_L,
    input  logic                  new_dat,
    input  logic                  write_read,
    input  logic [blk_cnt_w-1:0]  block_count,
    input  logic                  multiple_data,
    input  logic                  timeout_enable,
    input  logic [tmo_w-1:0]      timeout_reg,
    input  logic [fifo_lvl_w-1:0] fifo_level,
    sd_dat_ctrl_if.ctrl           ctrl,
    output logic                  transfer_complete,
    output logic                  timeout_error,
    output logic                  idle
);

logic [5:0] state;
logic [5:0] next_state;
logic       fifo_ok;
logic       timed_out;
logic       ack_done;

// write needs a full block queued, read needs room for one.
assign fifo_ok = ctrl.write_read ?
                 (fifo_level >= fifo_lvl_w'(block_bytes)) :
                 (fifo_lvl_w'(fifo_depth) - fifo_level >= fifo_lvl_w'(block_bytes));

assign ack_done          = (state == st_ack) && ctrl.ack_in;
assign transfer_complete = ack_done && !timed_out;
assign timeout_error     = ack_done && timed_out;
assign ctrl.idle         = idle;

always_comb
begin
    next_state = state;
    case (state)
        st_reset:
            next_state = st_idle;
        st_idle:
            if (new_dat)
                next_state = st_setting_outputs;
        st_setting_outputs:
            if (ctrl.serial_ready)
                next_state = st_check_fifo;
        st_check_fifo:
            if (fifo_ok)
                next_state = st_transmit;
        st_transmit:
            if (ctrl.complete || ctrl.timeout)
                next_state = st_ack;
        st_ack:
            if (ctrl.ack_in)
                next_state = st_idle;
        default:
            next_state = st_reset;
    endcase
end

// outputs follow the state they belong to.
always_ff @(posedge CLK)
begin
    if (!RESET_L)
    begin
        state        <= st_reset;
        idle         <= 1'b0;
        ctrl.strobe  <= 1'b0;
        ctrl.ack_out <= 1'b0;
        timed_out    <= 1'b0;
    end
    else
    begin
        state        <= next_state;
        idle         <= (next_state == st_idle);
        ctrl.strobe  <= (next_state == st_transmit);
        ctrl.ack_out <= (next_state == st_ack);
        if (state == st_transmit)
            timed_out <= ctrl.timeout;
    end
end

// transfer settings, held for the whole transfer.
always_ff @(posedge CLK)
begin
    if (state == st_setting_outputs)
    begin
        ctrl.blocks         <= block_count;
        ctrl.timeout_value  <= timeout_reg;
        ctrl.timeout_enable <= timeout_enable;
        ctrl.write_read     <= write_read;
        ctrl.multiple       <= multiple_data;
    end
end

endmodule

// File: source/sd_dat_phy.sv
`timescale 1ns/100ps

module sd_dat_phy
    import sd_data_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET_L,
    sd_dat_ctrl_if.phy ctrl,
    sd_fifo_if.phy     fifo,
    input  logic       dat_in,
    output logic       dat_out,
    output logic       dat_oe
);

logic [2:0]            state;
logic [bit_cnt_w-1:0]  bit_cnt;
logic [byte_cnt_w-1:0] byte_cnt;
logic [blk_cnt_w-1:0]  blk_cnt;
logic [byte_w-1:0]     shreg;
logic                  push_q;
logic                  last_bit;
logic                  last_byte;
logic                  last_blk;
logic                  start;
logic                  block_end;
logic                  wr_load;
logic                  tmr_load;
logic                  expired;

assign last_bit  = (bit_cnt == bit_cnt_w'(byte_w - 1));
assign last_byte = (byte_cnt == byte_cnt_w'(block_bytes - 1));
// single block unless multiple is set.
assign last_blk  = !ctrl.multiple || ({1'b0, blk_cnt} + 1'b1 >= {1'b0, ctrl.blocks});
assign start     = (state == ph_idle) && ctrl.strobe;
assign block_end = (state == ph_wr_stop) || (state == ph_rd_end);

// next byte is taken while the last bit of the current one goes out.
assign wr_load  = (start && ctrl.write_read) ||
                  ((state == ph_wr_data) && last_bit && !last_byte) ||
                  ((state == ph_wr_stop) && !last_blk);
assign tmr_load = start || block_end;

assign fifo.pop   = wr_load && !fifo.empty;
assign fifo.push  = push_q && !fifo.full;
assign fifo.wdata = shreg;

sd_timeout_timer sd_timeout_timer_i (
    .CLK     (CLK),
    .RESET_L (RESET_L),
    .load    (tmr_load),
    .run     (state == ph_rd_wait),
    .enable  (ctrl.timeout_enable),
    .value   (ctrl.timeout_value),
    .expired (expired)
);

// shared shift register, msb first in both directions.
always_ff @(posedge CLK)
begin
    if (wr_load)
        shreg <= fifo.rdata;
    else if ((state == ph_wr_data) || (state == ph_rd_data))
        shreg <= {shreg[byte_w-2:0], dat_in};
end

// ==========================================================================
// framing and handshake
// ==========================================================================
always_ff @(posedge CLK)
begin
    if (!RESET_L)
    begin
        state             <= ph_idle;
        bit_cnt           <= '0;
        byte_cnt          <= '0;
        blk_cnt           <= '0;
        push_q            <= 1'b0;
        dat_out           <= 1'b1;
        dat_oe            <= 1'b0;
        ctrl.serial_ready <= 1'b0;
        ctrl.complete     <= 1'b0;
        ctrl.timeout      <= 1'b0;
        ctrl.ack_in       <= 1'b0;
    end
    else
    begin
        push_q            <= 1'b0;
        ctrl.ack_in       <= 1'b0;
        ctrl.serial_ready <= ctrl.idle && (state == ph_idle);
        case (state)
            ph_idle:
                if (ctrl.strobe)
                begin
                    bit_cnt  <= '0;
                    byte_cnt <= '0;
                    blk_cnt  <= '0;
                    if (ctrl.write_read)
                    begin
                        dat_oe  <= 1'b1;
                        dat_out <= 1'b0;
                        state   <= ph_wr_data;
                    end
                    else
                    begin
                        state <= ph_rd_wait;
                    end
                end
            ph_wr_data:
            begin
                dat_out <= shreg[byte_w-1];
                bit_cnt <= bit_cnt + 1'b1;
                if (last_bit)
                begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (last_byte)
                        state <= ph_wr_end;
                end
            end
            ph_wr_end:
            begin
                dat_out <= 1'b1;
                state   <= ph_wr_stop;
            end
            ph_wr_stop:
            begin
                blk_cnt <= blk_cnt + 1'b1;
                if (last_blk)
                begin
                    dat_oe        <= 1'b0;
                    ctrl.complete <= 1'b1;
                    state         <= ph_done;
                end
                else
                begin
                    // next start bit, no gap.
                    dat_out <= 1'b0;
                    state   <= ph_wr_data;
                end
            end
            ph_rd_wait:
                if (!dat_in)
                begin
                    state <= ph_rd_data;
                end
                else if (expired)
                begin
                    ctrl.timeout <= 1'b1;
                    state        <= ph_done;
                end
            ph_rd_data:
            begin
                bit_cnt <= bit_cnt + 1'b1;
                if (last_bit)
                begin
                    push_q   <= 1'b1;
                    byte_cnt <= byte_cnt + 1'b1;
                    if (last_byte)
                        state <= ph_rd_end;
                end
            end
            ph_rd_end:
            begin
                // end bit slot, value not checked.
                blk_cnt <= blk_cnt + 1'b1;
                if (last_blk)
                begin
                    ctrl.complete <= 1'b1;
                    state         <= ph_done;
                end
                else
                begin
                    state <= ph_rd_wait;
                end
            end
            ph_done:
                if (ctrl.ack_out)
                begin
                    ctrl.complete <= 1'b0;
                    ctrl.timeout  <= 1'b0;
                    ctrl.ack_in   <= 1'b1;
                    state         <= ph_idle;
                end
            default:
                state <= ph_idle;
        endcase
    end
end

endmodule

// File: source/sd_data_fifo.sv
`timescale 1ns/100ps

module sd_data_fifo
    import sd_data_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET_L,
    input  logic                  host_push,
    input  logic [byte_w-1:0]     host_wdata,
    input  logic                  host_pop,
    output logic [byte_w-1:0]     host_rdata,
    output logic [fifo_lvl_w-1:0] level,
    sd_fifo_if.fifo               fifo
);

logic [byte_w-1:0]     mem [fifo_depth];
logic [fifo_ptr_w-1:0] wr_ptr;
logic [fifo_ptr_w-1:0] rd_ptr;
logic                  do_push;
logic                  do_pop;

assign fifo.empty = (level == '0);
assign fifo.full  = (level == fifo_lvl_w'(fifo_depth));

// only one side is active per transfer direction.
assign do_push = (host_push || fifo.push) && !fifo.full;
assign do_pop  = (host_pop || fifo.pop) && !fifo.empty;

assign fifo.rdata = mem[rd_ptr];
assign host_rdata = mem[rd_ptr];

always_ff @(posedge CLK)
begin
    if (do_push)
        mem[wr_ptr] <= fifo.push ? fifo.wdata : host_wdata;
end

always_ff @(posedge CLK)
begin
    if (!RESET_L)
    begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        level  <= '0;
    end
    else
    begin
        if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
        if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
        if (do_push && !do_pop)
            level <= level + 1'b1;
        else if (do_pop && !do_push)
            level <= level - 1'b1;
    end
end

endmodule

// File: source/sd_data_top.sv
`timescale 1ns/100ps

module sd_data_top
    import sd_data_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET_L,
    input  logic                  new_dat,
    input  logic                  write_read,
    input  logic [blk_cnt_w-1:0]  block_count,
    input  logic                  multiple_data,
    input  logic                  timeout_enable,
    input  logic [tmo_w-1:0]      timeout_reg,
    input  logic                  host_push,
    input  logic [byte_w-1:0]     host_wdata,
    input  logic                  host_pop,
    input  logic                  dat_in,
    output logic [byte_w-1:0]     host_rdata,
    output logic [fifo_lvl_w-1:0] fifo_level,
    output logic                  dat_out,
    output logic                  dat_oe,
    output logic                  transfer_complete,
    output logic                  timeout_error,
    output logic                  idle
);

sd_dat_ctrl_if ctrl_if ();
sd_fifo_if     fifo_if ();

sd_data_ctrl sd_data_ctrl_i (
    .CLK               (CLK),
    .RESET_L           (RESET_L),
    .new_dat           (new_dat),
    .write_read        (write_read),
    .block_count       (block_count),
    .multiple_data     (multiple_data),
    .timeout_enable    (timeout_enable),
    .timeout_reg       (timeout_reg),
    .fifo_level        (fifo_level),
    .ctrl              (ctrl_if.ctrl),
    .transfer_complete (transfer_complete),
    .timeout_error     (timeout_error),
    .idle              (idle)
);

sd_dat_phy sd_dat_phy_i (
    .CLK     (CLK),
    .RESET_L (RESET_L),
    .ctrl    (ctrl_if.phy),
    .fifo    (fifo_if.phy),
    .dat_in  (dat_in),
    .dat_out (dat_out),
    .dat_oe  (dat_oe)
);

sd_data_fifo sd_data_fifo_i (
    .CLK        (CLK),
    .RESET_L    (RESET_L),
    .host_push  (host_push),
    .host_wdata (host_wdata),
    .host_pop   (host_pop),
    .host_rdata (host_rdata),
    .level      (fifo_level),
    .fifo       (fifo_if.fifo)
);

endmodule

// File: tests/sd_data_tb.sv
`timescale 1ns/100ps

module sd_data_tb
    import sd_data_pkg::*;
();

localparam int clk_period   = 20;
localparam int reset_cycles = 10;
localparam int frame_cycles = block_bytes * byte_w + 2;
localparam int overhead     = 120;
localparam int read_tmo     = 200;
localparam int short_tmo    = 60;
// worst case of all tests, doubled.
localparam int watchdog_cycles =
    2 * (reset_cycles + 7 * overhead + 10 * frame_cycles + read_tmo + short_tmo);

logic                  CLK;
logic                  RESET_L;
logic                  new_dat;
logic                  write_read;
logic [blk_cnt_w-1:0]  block_count;
logic                  multiple_data;
logic                  timeout_enable;
logic [tmo_w-1:0]      timeout_reg;
logic                  host_push;
logic [byte_w-1:0]     host_wdata;
logic                  host_pop;
logic                  dat_in;
logic [byte_w-1:0]     host_rdata;
logic [fifo_lvl_w-1:0] fifo_level;
logic                  dat_out;
logic                  dat_oe;
logic                  transfer_complete;
logic                  timeout_error;
logic                  idle;

int                errors;
int                checks;
int                tests;
int                err_mark;
int                done_pulses;
int                tmo_pulses;
int                done_mark;
int                tmo_mark;
int                run_len;
int                oe_runs[$];
logic              line_bits[$];
logic              exp_bits[$];
logic [byte_w-1:0] sent[$];
string             cur_name;

sd_data_top sd_data_top_i (.*);

initial
begin
    CLK = 1'b0;
    forever #(clk_period / 2) CLK = ~CLK;
end

initial
begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles", watchdog_cycles);
    $display("TEST FAILED");
    $finish;
end

// ==========================================================================
// card model and pulse monitor
// ==========================================================================
always @(negedge CLK)
begin
    if (transfer_complete)
        done_pulses++;
    if (timeout_error)
        tmo_pulses++;
    if (dat_oe)
    begin
        line_bits.push_back(dat_out);
        run_len++;
    end
    else if (run_len != 0)
    begin
        oe_runs.push_back(run_len);
        run_len = 0;
    end
end

task automatic note_error(input string msg);
    errors++;
    $display("%s", msg);
endtask

assert property (@(posedge CLK) disable iff (!RESET_L) !dat_oe |-> dat_out)
else
    note_error("dat_out low while the data line is not driven");

assert property (@(posedge CLK) disable iff (!RESET_L) idle |-> !dat_oe)
else
    note_error("dat_oe high while the controller is idle");

assert property (@(posedge CLK) disable iff (!RESET_L)
                 transfer_complete |=> !transfer_complete)
else
    note_error("transfer_complete held longer than one cycle");

task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    assert (expected == actual)
    else
        note_error($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
endtask

task automatic begin_test(input string name);
    cur_name = name;
    err_mark = errors;
    done_mark = done_pulses;
    tmo_mark = tmo_pulses;
    sent.delete();
    line_bits.delete();
    oe_runs.delete();
endtask

task automatic end_test();
    @(negedge CLK);
    check_value({cur_name, " idle"}, 1, idle);
    tests++;
    $display("%s: %s", cur_name, (errors == err_mark) ? "passed" : "failed");
endtask

task automatic make_bytes(input int n);
    int i;
    for (i = 0; i < n; i++)
        sent.push_back(8'($urandom));
endtask

task automatic push_range(input int first, input int n);
    int i;
    for (i = 0; i < n; i++)
    begin
        @(posedge CLK);
        host_push  <= 1'b1;
        host_wdata <= sent[first + i];
        @(posedge CLK);
        host_push <= 1'b0;
    end
endtask

task automatic pop_compare(input int first, input int n);
    logic [byte_w-1:0] d;
    int                i;
    for (i = 0; i < n; i++)
    begin
        @(negedge CLK);
        d = host_rdata;
        @(posedge CLK);
        host_pop <= 1'b1;
        @(posedge CLK);
        host_pop <= 1'b0;
        check_value($sformatf("%s byte %0d", cur_name, first + i), sent[first + i], d);
    end
endtask

task automatic start_transfer(input logic wr, input int blocks, input logic mult,
                              input logic tmo_en, input int tmo);
    @(posedge CLK);
    write_read     <= wr;
    block_count    <= blk_cnt_w'(blocks);
    multiple_data  <= mult;
    timeout_enable <= tmo_en;
    timeout_reg    <= tmo_w'(tmo);
    new_dat        <= 1'b1;
    @(posedge CLK);
    new_dat <= 1'b0;
endtask

// returns on the edge after a completion or timeout pulse.
task automatic wait_done(input int max_cycles);
    int n;
    n = 0;
    do
    begin
        @(negedge CLK);
        n++;
    end
    while (!transfer_complete && !timeout_error && n < max_cycles);
    if (!transfer_complete && !timeout_error)
        note_error($sformatf("%s: transfer did not end within %0d cycles",
                             cur_name, max_cycles));
    @(posedge CLK);
endtask

// start bit, bytes msb first, end bit.
task automatic send_block(input int first);
    int i;
    int b;
    @(posedge CLK);
    dat_in <= 1'b0;
    for (i = 0; i < block_bytes; i++)
        for (b = byte_w - 1; b >= 0; b--)
        begin
            @(posedge CLK);
            dat_in <= sent[first + i][b];
        end
    @(posedge CLK);
    dat_in <= 1'b1;
endtask

task automatic compare_frames(input int blocks, input int oe_len);
    int k;
    int i;
    int b;
    int bad;
    exp_bits.delete();
    for (k = 0; k < blocks; k++)
    begin
        exp_bits.push_back(1'b0);
        for (i = 0; i < block_bytes; i++)
            for (b = byte_w - 1; b >= 0; b--)
                exp_bits.push_back(sent[k * block_bytes + i][b]);
        exp_bits.push_back(1'b1);
    end
    bad = -1;
    check_value({cur_name, " bits"}, exp_bits.size(), line_bits.size());
    for (i = 0; i < exp_bits.size() && i < line_bits.size(); i++)
        if (bad < 0 && line_bits[i] !== exp_bits[i])
            bad = i;
    if (bad >= 0)
        check_value($sformatf("%s bit %0d", cur_name, bad), exp_bits[bad], line_bits[bad]);
    check_value({cur_name, " dat_oe runs"}, 1, oe_runs.size());
    if (oe_runs.size() != 0)
        check_value({cur_name, " dat_oe cycles"}, oe_len, oe_runs[0]);
endtask

task automatic check_pulses(input int done_n, input int tmo_n);
    check_value({cur_name, " transfer_complete"}, done_n, done_pulses - done_mark);
    check_value({cur_name, " timeout_error"}, tmo_n, tmo_pulses - tmo_mark);
endtask

// ==========================================================================
// test sequence
// ==========================================================================
initial
begin
    void'($urandom(40));
    RESET_L = 1'b0;
    new_dat = 1'b0;
    write_read = 1'b0;
    block_count = '0;
    multiple_data = 1'b0;
    timeout_enable = 1'b0;
    timeout_reg = '0;
    host_push = 1'b0;
    host_wdata = '0;
    host_pop = 1'b0;
    dat_in = 1'b1;
    repeat (reset_cycles) @(posedge CLK);
    RESET_L <= 1'b1;

    begin_test("reset_state");
    @(posedge CLK);
    @(negedge CLK);
    check_value("reset_state dat_oe", 0, dat_oe);
    check_value("reset_state dat_out", 1, dat_out);
    end_test();

    begin_test("write_single");
    make_bytes(block_bytes);
    push_range(0, block_bytes);
    start_transfer(1'b1, 1, 1'b0, 1'b0, 0);
    wait_done(frame_cycles + overhead);
    compare_frames(1, frame_cycles);
    check_pulses(1, 0);
    end_test();

    begin_test("write_multi");
    make_bytes(3 * block_bytes);
    push_range(0, 3 * block_bytes);
    start_transfer(1'b1, 3, 1'b1, 1'b0, 0);
    wait_done(3 * frame_cycles + overhead);
    compare_frames(3, 3 * frame_cycles);
    check_pulses(1, 0);
    check_value("write_multi fifo_level", 0, fifo_level);
    end_test();

    // block count ignored without multiple.
    begin_test("write_multi_off");
    make_bytes(2 * block_bytes);
    push_range(0, 2 * block_bytes);
    start_transfer(1'b1, 3, 1'b0, 1'b0, 0);
    wait_done(frame_cycles + overhead);
    compare_frames(1, frame_cycles);
    check_value("write_multi_off fifo_level", block_bytes, fifo_level);
    pop_compare(block_bytes, block_bytes);
    end_test();

    begin_test("write_underfill");
    make_bytes(block_bytes);
    push_range(0, 2);
    start_transfer(1'b1, 1, 1'b0, 1'b0, 0);
    repeat (2 * frame_cycles) @(negedge CLK);
    check_value("write_underfill early bits", 0, line_bits.size());
    push_range(2, block_bytes - 2);
    wait_done(frame_cycles + overhead);
    compare_frames(1, frame_cycles);
    check_pulses(1, 0);
    end_test();

    begin_test("read_blocks");
    make_bytes(2 * block_bytes);
    start_transfer(1'b0, 2, 1'b1, 1'b1, read_tmo);
    repeat (10 + $urandom % 80) @(posedge CLK);
    send_block(0);
    repeat ($urandom % 6) @(posedge CLK);
    send_block(block_bytes);
    wait_done(overhead);
    check_pulses(1, 0);
    check_value("read_blocks fifo_level", 2 * block_bytes, fifo_level);
    pop_compare(0, 2 * block_bytes);
    end_test();

    begin_test("read_timeout");
    start_transfer(1'b0, 1, 1'b0, 1'b1, short_tmo);
    wait_done(short_tmo + overhead);
    check_pulses(0, 1);
    check_value("read_timeout fifo_level", 0, fifo_level);
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
        $display("TEST OK");
    else
        $display("TEST FAILED");
    $finish;
end

endmodule

// File: files.f
source/sd_data_pkg.sv
source/sd_dat_ctrl_if.sv
source/sd_fifo_if.sv
source/sd_timeout_timer.sv
source/sd_data_ctrl.sv
source/sd_dat_phy.sv
source/sd_data_fifo.sv
source/sd_data_top.sv
tests/sd_data_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= sd_data_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
